// File: axil_sram.f
axil_sram_pkg.sv
sram_sp_impl_plain.sv
axil_sram_wr_ctrl.sv
axil_sram_rd_ctrl.sv
sram_port_arb.sv
axil_sram_top.sv
tb_axil_sram.sv

// File: axil_sram_pkg.sv
// shared sizes, memory request struct and address decode union for the axi-lite sram
`default_nettype none

package axil_sram_pkg;

   // bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;   // one strobe per byte

   // memory geometry
   localparam int MEM_SIZE_BYTES = 1024;
   localparam int MEM_WORDS      = MEM_SIZE_BYTES / STRB_W;
   localparam int WORD_AW        = $clog2(MEM_WORDS);
   localparam int OFFS_W         = $clog2(STRB_W);
   localparam int HIGH_W         = ADDR_W - WORD_AW - OFFS_W;   // bits above the memory

   // axi response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // byte address split into range bits, word index and byte lane
   typedef struct packed {
      logic [HIGH_W-1:0]  high;   // nonzero means past the end
      logic [WORD_AW-1:0] word;
      logic [OFFS_W-1:0]  offs;   // ignored, accesses are word aligned
   } axil_addr_fields_t;

   // one address word, seen raw or decoded
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      axil_addr_fields_t f;
   } axil_addr_u;

   // single request toward the memory port, 45 bits
   typedef struct packed {
      logic               write;   // 1 write, 0 read
      logic [WORD_AW-1:0] word;
      logic [DATA_W-1:0]  data;
      logic [STRB_W-1:0]  sel;
   } sram_req_t;

endpackage

`default_nettype wire

// File: axil_sram_rd_ctrl.sv
// axi-lite read channel controller, takes ar, reads through the port, returns r
`timescale 1ns/1ps
`default_nettype none

module axil_sram_rd_ctrl (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              arvalid,
   output logic                              arready,
   input  logic [axil_sram_pkg::ADDR_W-1:0]  araddr,
   output logic                              rvalid,
   input  logic                              rready,
   output logic [axil_sram_pkg::DATA_W-1:0]  rdata,
   output logic [1:0]                        rresp,
   output axil_sram_pkg::sram_req_t          req,
   output logic                              req_valid,
   input  logic                              grant,
   input  logic [axil_sram_pkg::DATA_W-1:0]  dout
);
   import axil_sram_pkg::*;

   // wait for grant, wait for memory latency, wait for rready
   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} state_t;

   state_t             state;
   logic               ar_hs;
   axil_addr_u         ar_addr;
   logic [WORD_AW-1:0] word_q;

   assign ar_hs = arvalid & arready;

   always_comb ar_addr.raw = araddr;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         arready <= 1'b0;
         rresp   <= RESP_OKAY;
      end else begin
         case (state)
            ST_IDLE: begin
               if (ar_hs) begin
                  arready <= 1'b0;
                  word_q  <= ar_addr.f.word;
                  if (ar_addr.f.high != '0) begin
                     rresp <= RESP_SLVERR;   // skip memory, zero data
                     rdata <= '0;
                     state <= ST_RESP;
                  end else begin
                     state <= ST_REQ;
                  end
               end else begin
                  arready <= 1'b1;
               end
            end
            ST_REQ:  if (grant) state <= ST_WAIT;   // address registered in sram
            ST_WAIT: begin                         // oe high, dout valid now
               rdata <= dout;
               rresp <= RESP_OKAY;
               state <= ST_RESP;
            end
            ST_RESP: if (rready) begin
               state   <= ST_IDLE;
               arready <= 1'b1;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_comb begin
      req.write = 1'b0;
      req.word  = word_q;
      req.data  = '0;
      req.sel   = '1;
   end

   assign req_valid = (state == ST_REQ);
   assign rvalid    = (state == ST_RESP);

   // r stays up with stable payload until taken
   a_r_hold : assert property (
      @(posedge clk) disable iff (rst)
         rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
   ) else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

// File: axil_sram_top.sv
// axi-lite slave scratch memory, wires the two channel controllers, arbiter and sram together
`timescale 1ns/1ps
`default_nettype none

module axil_sram_top (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              awvalid,
   output logic                              awready,
   input  logic [axil_sram_pkg::ADDR_W-1:0]  awaddr,
   input  logic                              wvalid,
   output logic                              wready,
   input  logic [axil_sram_pkg::DATA_W-1:0]  wdata,
   input  logic [axil_sram_pkg::STRB_W-1:0]  wstrb,
   output logic                              bvalid,
   input  logic                              bready,
   output logic [1:0]                        bresp,
   input  logic                              arvalid,
   output logic                              arready,
   input  logic [axil_sram_pkg::ADDR_W-1:0]  araddr,
   output logic                              rvalid,
   input  logic                              rready,
   output logic [axil_sram_pkg::DATA_W-1:0]  rdata,
   output logic [1:0]                        rresp
);
   import axil_sram_pkg::*;

   sram_req_t          wr_req;
   sram_req_t          rd_req;
   logic               wr_req_valid;
   logic               rd_req_valid;
   logic               wr_grant;
   logic               rd_grant;
   logic               mem_ce;
   logic               mem_we;
   logic               mem_oe;
   logic [WORD_AW-1:0] mem_addr;
   logic [DATA_W-1:0]  mem_din;
   logic [STRB_W-1:0]  mem_sel;
   logic [DATA_W-1:0]  mem_dout;   // only nonzero in the read data cycle

   axil_sram_wr_ctrl u_wr_ctrl (
      .clk, .rst,
      .awvalid, .awready, .awaddr,
      .wvalid, .wready, .wdata, .wstrb,
      .bvalid, .bready, .bresp,
      .req(wr_req), .req_valid(wr_req_valid), .grant(wr_grant)
   );

   axil_sram_rd_ctrl u_rd_ctrl (
      .clk, .rst,
      .arvalid, .arready, .araddr,
      .rvalid, .rready, .rdata, .rresp,
      .req(rd_req), .req_valid(rd_req_valid), .grant(rd_grant), .dout(mem_dout)
   );

   sram_port_arb u_arb (
      .clk, .rst,
      .wr_req, .wr_valid(wr_req_valid), .rd_req, .rd_valid(rd_req_valid),
      .wr_grant, .rd_grant,
      .ce(mem_ce), .we(mem_we), .oe(mem_oe), .addr(mem_addr), .din(mem_din), .sel(mem_sel)
   );

   sram_sp_impl_plain u_mem (
      .clk, .rst,
      .ce(mem_ce), .we(mem_we), .oe(mem_oe),
      .addr(mem_addr), .din(mem_din), .sel(mem_sel), .dout(mem_dout)
   );

endmodule

`default_nettype wire

// File: axil_sram_wr_ctrl.sv
// axi-lite write channel controller, gathers aw and w, range-checks, drives the port, answers b
`timescale 1ns/1ps
`default_nettype none

module axil_sram_wr_ctrl (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              awvalid,
   output logic                              awready,
   input  logic [axil_sram_pkg::ADDR_W-1:0]  awaddr,
   input  logic                              wvalid,
   output logic                              wready,
   input  logic [axil_sram_pkg::DATA_W-1:0]  wdata,
   input  logic [axil_sram_pkg::STRB_W-1:0]  wstrb,
   output logic                              bvalid,
   input  logic                              bready,
   output logic [1:0]                        bresp,
   output axil_sram_pkg::sram_req_t          req,
   output logic                              req_valid,
   input  logic                              grant
);
   import axil_sram_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} state_t;

   state_t            state;
   logic              have_aw;    // address latched
   logic              have_w;     // data latched
   logic              aw_hs;
   logic              w_hs;
   axil_addr_u        addr_q;
   axil_addr_u        addr_cur;   // address as of this cycle, for the range check
   logic [DATA_W-1:0] data_q;
   logic [STRB_W-1:0] strb_q;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;

   always_comb addr_cur.raw = aw_hs ? awaddr : addr_q.raw;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         awready <= 1'b0;
         wready  <= 1'b0;
         have_aw <= 1'b0;
         have_w  <= 1'b0;
         bresp   <= RESP_OKAY;
      end else begin
         case (state)
            ST_IDLE: begin
               if (aw_hs) begin
                  have_aw <= 1'b1;
                  awready <= 1'b0;
               end else if (!have_aw) begin
                  awready <= 1'b1;   // first idle cycle after reset
               end
               if (w_hs) begin
                  have_w <= 1'b1;
                  wready <= 1'b0;
               end else if (!have_w) begin
                  wready <= 1'b1;
               end
               // both halves in hand, go to port or error out
               if ((have_aw || aw_hs) && (have_w || w_hs)) begin
                  if (addr_cur.f.high != '0) begin
                     bresp <= RESP_SLVERR;   // no memory access
                     state <= ST_RESP;
                  end else begin
                     state <= ST_REQ;
                  end
               end
            end
            ST_REQ: if (grant) begin   // memory written at this edge
               bresp <= RESP_OKAY;
               state <= ST_RESP;
            end
            ST_RESP: if (bready) begin
               state   <= ST_IDLE;
               have_aw <= 1'b0;
               have_w  <= 1'b0;
               awready <= 1'b1;
               wready  <= 1'b1;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) addr_q.raw <= awaddr;
      if (w_hs) begin
         data_q <= wdata;
         strb_q <= wstrb;
      end
   end

   always_comb begin
      req.write = 1'b1;
      req.word  = addr_q.f.word;
      req.data  = data_q;
      req.sel   = strb_q;
   end

   assign req_valid = (state == ST_REQ);
   assign bvalid    = (state == ST_RESP);

   // b stays up with a stable code until taken
   a_b_hold : assert property (
      @(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid && $stable(bresp)
   ) else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

// File: sram_port_arb.sv
// alternating-priority arbiter between write and read requests for the single sram port
`timescale 1ns/1ps
`default_nettype none

module sram_port_arb (
   input  logic                               clk,
   input  logic                               rst,
   input  axil_sram_pkg::sram_req_t           wr_req,
   input  logic                               wr_valid,
   input  axil_sram_pkg::sram_req_t           rd_req,
   input  logic                               rd_valid,
   output logic                               wr_grant,
   output logic                               rd_grant,
   output logic                               ce,
   output logic                               we,
   output logic                               oe,
   output logic [axil_sram_pkg::WORD_AW-1:0]  addr,
   output logic [axil_sram_pkg::DATA_W-1:0]   din,
   output logic [axil_sram_pkg::STRB_W-1:0]   sel
);
   import axil_sram_pkg::*;

   logic      last_wr;   // write won the last contested or single grant
   sram_req_t win;

   // on contention the side not served last time goes first
   assign wr_grant = wr_valid && (!rd_valid || !last_wr);
   assign rd_grant = rd_valid && (!wr_valid || last_wr);

   always_ff @(posedge clk) begin
      if (rst) begin
         last_wr <= 1'b0;
         oe      <= 1'b0;
      end else begin
         if (wr_grant) begin
            last_wr <= 1'b1;
         end else if (rd_grant) begin
            last_wr <= 1'b0;
         end
         oe <= rd_grant;   // data cycle follows the read grant
      end
   end

   assign win  = wr_grant ? wr_req : rd_req;
   assign ce   = wr_grant | rd_grant;
   assign we   = ce & win.write;
   assign addr = win.word;
   assign din  = win.data;
   assign sel  = win.sel;

   a_one_grant : assert property (
      @(posedge clk) disable iff (rst) !(wr_grant && rd_grant)
   ) else $error("write and read granted together");

   // a held request never waits more than one extra cycle
   a_wr_served : assert property (
      @(posedge clk) disable iff (rst) wr_valid |-> ##[0:1] wr_grant
   ) else $error("write request starved");

   a_rd_served : assert property (
      @(posedge clk) disable iff (rst) rd_valid |-> ##[0:1] rd_grant
   ) else $error("read request starved");

endmodule

`default_nettype wire

// File: sram_sp_impl_plain.sv
// single-port register-array memory, byte selects on write, one cycle read latency
`timescale 1ns/1ps
`default_nettype none

module sram_sp_impl_plain (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               ce,     // chip enable
   input  logic                               we,     // write enable
   input  logic                               oe,     // output enable, data cycle
   input  logic [axil_sram_pkg::WORD_AW-1:0]  addr,   // word index
   input  logic [axil_sram_pkg::DATA_W-1:0]   din,
   input  logic [axil_sram_pkg::STRB_W-1:0]   sel,    // byte selects
   output logic [axil_sram_pkg::DATA_W-1:0]   dout
);
   import axil_sram_pkg::*;

   logic [DATA_W-1:0]  mem [MEM_WORDS];
   logic [WORD_AW-1:0] addr_r;   // read address, latched on a read access

   // read address register gives the one cycle latency
   always_ff @(posedge clk) begin
      if (rst) begin
         addr_r <= '0;
      end else if (ce && !we) begin
         addr_r <= addr;
      end
   end

   // byte-lane writes
   always_ff @(posedge clk) begin
      if (ce && we) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (sel[i]) begin
               mem[addr][i*8 +: 8] <= din[i*8 +: 8];   // unselected lanes keep old value
            end
         end
      end
   end

   // output driven only in the data cycle
   assign dout = oe ? mem[addr_r] : '0;

   // write strobe must come with chip enable
   a_we_needs_ce : assert property (
      @(posedge clk) disable iff (rst) we |-> ce
   ) else $error("sram write enable without chip enable");

endmodule

`default_nettype wire

// File: tb_axil_sram.sv
// self-checking simulation top that drives axil_sram_top over axi-lite and checks each response
`timescale 1ns/1ps
`default_nettype none

module tb_axil_sram;
   import axil_sram_pkg::*;

   localparam int N_ROUNDS = 8;    // concurrent traffic rounds
   localparam int N_RAND   = 12;   // writes and reads per round
   // full writes, two full readbacks, strobes, out of range, misaligned, random rounds
   localparam int N_TXN    = 3*MEM_WORDS + 32 + 16 + 24 + N_ROUNDS*3*N_RAND;
   localparam longint LIMIT_NS = 5*20 + longint'(N_TXN)*40*20;

   typedef struct packed {
      logic [1:0]        resp;
      logic [DATA_W-1:0] word;   // new word on writes and current word on reads
   } expect_t;

   logic clk, rst;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [ADDR_W-1:0] awaddr, araddr;
   logic [DATA_W-1:0] wdata, rdata;
   logic [STRB_W-1:0] wstrb;
   logic [1:0]        bresp, rresp;

   logic [DATA_W-1:0] model [MEM_WORDS];   // expected memory contents
   bit                written [MEM_WORDS];
   logic [1:0]        exp_bresp [$];
   logic [1:0]        exp_rresp [$];
   logic [DATA_W-1:0] exp_rdata [$];
   bit                exp_rchk [$];        // 0 when the word may be changing
   int wr_sent = 0, rd_sent = 0, b_done = 0, r_done = 0;
   int b_left = 0, r_left = 0;

   axil_sram_top uut (.*);

   always #10 clk = ~clk;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "stopping on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
         fail_run("response value check failed");
      end
   endtask

   function automatic int word_of(input logic [ADDR_W-1:0] addr);
      return (addr / STRB_W) % MEM_WORDS;   // low two bits dropped
   endfunction

   // expected result of one access from the old word, data, strobes and address
   function automatic expect_t ref_access(input logic [DATA_W-1:0] old,
                                          input logic [DATA_W-1:0] data,
                                          input logic [STRB_W-1:0] strb,
                                          input logic [ADDR_W-1:0] addr);
      expect_t e;
      e.word = old;
      if (addr >= MEM_SIZE_BYTES) begin
         e.resp = RESP_SLVERR;   // past the end and no write
      end else begin
         e.resp = RESP_OKAY;
         for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) e.word[i*8 +: 8] = data[i*8 +: 8];
         end
      end
      return e;
   endfunction

   task automatic drive_aw(input logic [ADDR_W-1:0] a, input int dly);
      repeat (dly) @(negedge clk);
      awaddr  = a;
      awvalid = 1'b1;
      do @(posedge clk); while (!awready);
      @(negedge clk);
      awvalid = 1'b0;
   endtask

   task automatic drive_w(input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s, input int dly);
      repeat (dly) @(negedge clk);
      wdata  = d;
      wstrb  = s;
      wvalid = 1'b1;
      do @(posedge clk); while (!wready);
      @(negedge clk);
      wvalid = 1'b0;
   endtask

   // one write with aw and w in random order and a wait for b
   task automatic write_access(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                               input logic [STRB_W-1:0] s);
      expect_t e;
      int      w, d_aw, d_w;
      w    = word_of(a);
      d_aw = $urandom % 3;
      d_w  = $urandom % 3;
      e    = ref_access(model[w], d, s, a);
      if (e.resp == RESP_OKAY) begin
         model[w]   = e.word;
         written[w] = 1'b1;
      end
      exp_bresp.push_back(e.resp);
      wr_sent++;
      @(negedge clk);
      fork
         drive_aw(a, d_aw);
         drive_w(d, s, d_w);
      join
      wait (b_done == wr_sent);
   endtask

   task automatic read_access(input logic [ADDR_W-1:0] a, input bit chk);
      expect_t e;
      int      w;
      w = word_of(a);
      e = ref_access(model[w], '0, '0, a);
      exp_rresp.push_back(e.resp);
      exp_rdata.push_back(e.resp == RESP_OKAY ? e.word : '0);   // zero data on slverr
      exp_rchk.push_back(e.resp != RESP_OKAY || (chk && written[w]));
      rd_sent++;
      @(negedge clk);
      araddr  = a;
      arvalid = 1'b1;
      do @(posedge clk); while (!arready);
      @(negedge clk);
      arvalid = 1'b0;
      wait (r_done == rd_sent);
   endtask

   // ready stalls in random stretches
   always @(negedge clk) begin
      if (b_left == 0) begin
         bready = ($urandom % 4 != 0);
         b_left = 1 + $urandom % 5;
      end else b_left--;
      if (r_left == 0) begin
         rready = ($urandom % 4 != 0);
         r_left = 1 + $urandom % 5;
      end else r_left--;
   end

   // compare every b and r handshake against the queued expectation
   always @(posedge clk) begin
      if (!rst && bvalid && bready) begin
         if (exp_bresp.size() == 0) fail_run("write response arrived with no write outstanding");
         else begin
            check_value("bresp", bresp, exp_bresp.pop_front());
            b_done++;
         end
      end
      if (!rst && rvalid && rready) begin
         if (exp_rresp.size() == 0) fail_run("read response arrived with no read outstanding");
         else begin
            check_value("rresp", rresp, exp_rresp.pop_front());
            if (exp_rchk.pop_front()) check_value("rdata", rdata, exp_rdata.pop_front());
            else void'(exp_rdata.pop_front());
            r_done++;
         end
      end
   end

   initial begin
      #(LIMIT_NS);
      fail_run("simulation hung, watchdog expired before all transactions finished");
   end

   initial begin
      logic [ADDR_W-1:0] wa [N_RAND];
      logic [ADDR_W-1:0] a, ra;
      bit                busy [MEM_WORDS];   // words written in the current round
      void'($urandom(32'hbbe4));
      clk = 1'b0;
      rst = 1'b1;
      {awvalid, wvalid, arvalid, bready, rready} = '0;
      awaddr = '0;
      araddr = '0;
      wdata  = '0;
      wstrb  = '0;
      repeat (5) begin
         @(negedge clk);
         check_value("bvalid", bvalid, 1'b0);
         check_value("rvalid", rvalid, 1'b0);
         check_value("awready", awready, 1'b0);
         check_value("wready", wready, 1'b0);
         check_value("arready", arready, 1'b0);
      end
      rst = 1'b0;
      @(negedge clk);
      check_value("bvalid", bvalid, 1'b0);   // first cycle out of reset
      check_value("rvalid", rvalid, 1'b0);
      check_value("awready", awready, 1'b1);   // readies up one cycle after reset
      check_value("wready", wready, 1'b1);
      check_value("arready", arready, 1'b1);
      for (int i = 0; i < MEM_WORDS; i++) write_access(i*4, $urandom, 4'hf);
      for (int i = 0; i < MEM_WORDS; i++) read_access(i*4, 1'b1);
      for (int i = 0; i < 16; i++) begin   // partial strobes
         a = ($urandom % MEM_WORDS) * 4;
         write_access(a, $urandom, 4'($urandom % 14 + 1));
         read_access(a, 1'b1);
      end
      for (int i = 0; i < 8; i++) begin    // out of range with the first two on the edges
         a = (i == 0) ? MEM_SIZE_BYTES :
             (i == 1) ? 32'hffff_fffc : MEM_SIZE_BYTES + $urandom % 32'h10_0000;
         write_access(a, $urandom, 4'($urandom));
         read_access(a, 1'b1);
      end
      for (int i = 0; i < MEM_WORDS; i++) read_access(i*4, 1'b1);   // nothing disturbed
      for (int i = 0; i < 8; i++) begin    // misaligned hits the aligned word
         a = ($urandom % MEM_WORDS) * 4;
         write_access(a | (1 + $urandom % 3), $urandom, 4'hf);
         read_access(a | (1 + $urandom % 3), 1'b1);
         read_access(a, 1'b1);
      end
      for (int r = 0; r < N_ROUNDS; r++) begin
         for (int i = 0; i < MEM_WORDS; i++) busy[i] = 1'b0;
         for (int i = 0; i < N_RAND; i++) begin
            wa[i] = ($urandom % 8 == 0) ? MEM_SIZE_BYTES + $urandom % 4096
                                        : $urandom % MEM_SIZE_BYTES;
            busy[word_of(wa[i])] = 1'b1;
         end
         fork
            for (int i = 0; i < N_RAND; i++) write_access(wa[i], $urandom, 4'($urandom));
            for (int i = 0; i < N_RAND; i++) begin
               ra = ($urandom % 8 == 0) ? MEM_SIZE_BYTES + $urandom % 4096
                                        : $urandom % MEM_SIZE_BYTES;
               read_access(ra, !busy[word_of(ra)]);
            end
         join
         for (int i = 0; i < MEM_WORDS; i++) begin
            if (busy[i]) read_access(i*4, 1'b1);   // settled after all b responses
         end
      end
      repeat (2) @(negedge clk);
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire
